/* src.f */
design/sdram_front_pkg.sv
design/bank_req_if.sv
design/row_upd_if.sv
design/bank_req_latch.sv
design/open_row_tracker.sv
design/bank_cmd_seq.sv
design/sdram_front.sv
testbench/tb_sdram_front.sv

/* run.sh */
#!/bin/bash
# build and run the testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module tb_sdram_front -o sim \
    && ./obj_dir/sim > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "Something failed" sim.log \
    && echo "simulation passed" \
    || { [ -f sim.log ] && cat sim.log; echo "simulation failed"; exit 1; }

/* testbench/tb_sdram_front.sv */
`timescale 1ns/1ns

module tb_sdram_front;

    localparam int n_req      = 200;                     // requests over all banks
    localparam int n_per_bank = n_req / sdram_front_pkg::nbank;
    localparam int max_cycles = n_req * 12 + 200;        // watchdog limit

    typedef struct packed {
        logic [sdram_front_pkg::cmd_w-1:0] cmd;
        logic [sdram_front_pkg::ba_w-1:0]  ba;
        logic [sdram_front_pkg::row_w-1:0] addr;
    } entry_t;
    typedef entry_t entry_q_t [$];

    logic                                                            rst;
    logic                                                            clk;
    logic [sdram_front_pkg::nbank-1:0][sdram_front_pkg::aw-1:0]      addr;
    logic [sdram_front_pkg::nbank-1:0]                               rd;
    logic [sdram_front_pkg::nbank-1:0]                               wr;
    logic [sdram_front_pkg::nbank-1:0]                               ack;
    logic [sdram_front_pkg::cmd_w-1:0]                               cmd;
    logic [sdram_front_pkg::ba_w-1:0]                                cmd_ba;
    logic [sdram_front_pkg::row_w-1:0]                               cmd_addr;
    logic                                                            idle;

    logic [sdram_front_pkg::nbank-1:0][sdram_front_pkg::aw-1:0]      cur_addr; // held per client
    logic [sdram_front_pkg::nbank-1:0]                               cur_wr;
    logic [sdram_front_pkg::nbank-1:0]                               m_open;   // model open flags
    logic [sdram_front_pkg::nbank-1:0][sdram_front_pkg::row_w-1:0]   m_rows;   // model open rows
    logic [sdram_front_pkg::nbank-1:0] hist0, hist1, hist2;  // pending sets with newest first
    entry_q_t                          exp_q;                // commands still due
    int                                last_ba;              // last bank served
    int                                cur_bank;
    int                                ack_cnt [sdram_front_pkg::nbank];
    int                                cmd_errs, ack_errs, seq_errs;

    sdram_front #(
        .latch_en (1)
    ) DUT (
        .rst      (rst),
        .clk      (clk),
        .addr     (addr),
        .rd       (rd),
        .wr       (wr),
        .ack      (ack),
        .cmd      (cmd),
        .cmd_ba   (cmd_ba),
        .cmd_addr (cmd_addr),
        .idle     (idle)
    );

    always #20 clk = ~clk;                               // 40 ns period

    // ----------------------------------------------------------------------
    // reference model giving the expected commands for one request
    // ----------------------------------------------------------------------
    function automatic entry_q_t expect_cmds(
        inout logic [sdram_front_pkg::nbank-1:0]                          open_t,
        inout logic [sdram_front_pkg::nbank-1:0][sdram_front_pkg::row_w-1:0] row_t,
        input int                                                         b,
        input logic [sdram_front_pkg::aw-1:0]                             a,
        input logic                                                       w
    );
        entry_q_t                          q;
        entry_t                            e;
        logic [sdram_front_pkg::row_w-1:0] row;
        row  = a[sdram_front_pkg::aw-1 -: sdram_front_pkg::row_w];
        e.ba = sdram_front_pkg::ba_w'(b);
        if (open_t[b] && row_t[b] != row) begin         // row miss closes the bank first
            e.cmd  = sdram_front_pkg::cmd_pre;
            e.addr = '0;
            q.push_back(e);
            open_t[b] = 1'b0;
        end
        if (!open_t[b]) begin                            // closed bank needs an activate
            e.cmd  = sdram_front_pkg::cmd_act;
            e.addr = row;
            q.push_back(e);
            open_t[b] = 1'b1;
            row_t[b]  = row;
        end
        e.cmd  = w ? sdram_front_pkg::cmd_wr : sdram_front_pkg::cmd_rd;
        e.addr = sdram_front_pkg::row_w'(a[sdram_front_pkg::col_w-1:0]);  // zero-extended column
        q.push_back(e);
        return q;
    endfunction

    // first pending bank after the last one served or -1 when none
    function automatic int next_bank(input logic [sdram_front_pkg::nbank-1:0] p, input int last);
        int b;
        for (int i = 1; i <= sdram_front_pkg::nbank; i++) begin
            b = (last + i) % sdram_front_pkg::nbank;
            if (p[b]) begin
                return b;
            end
        end
        return -1;
    endfunction

    // one client port holding a level request until ack
    task automatic client(input int b);
        logic [sdram_front_pkg::row_w-1:0] row;
        logic                              w;
        for (int n = 0; n < n_per_bank; n++) begin
            repeat (1 + $urandom % 6) @(negedge clk);
            row = sdram_front_pkg::row_w'(b * 300 + 17 + ($urandom % 2) * 4000);  // two rows
            w   = 1'($urandom % 2);
            cur_addr[b] = {row, sdram_front_pkg::col_w'($urandom)};
            cur_wr[b]   = w;
            addr[b]     = cur_addr[b];
            rd[b]       = ~w;
            wr[b]       = w;
            @(posedge clk);
            while (!ack[b]) @(posedge clk);
            @(negedge clk);                              // drop one cycle after ack
            rd[b] = 1'b0;
            wr[b] = 1'b0;
        end
    endtask

    // ----------------------------------------------------------------------
    // monitor comparing the command bus with the model
    // ----------------------------------------------------------------------
    always @(posedge clk) begin : monitor
        entry_t                            e;
        int                                rb;
        logic [sdram_front_pkg::nbank-1:0] done;
        if (!rst) begin
            done  = '0;
            hist2 = hist1;
            hist1 = hist0;
            for (int b = 0; b < sdram_front_pkg::nbank; b++) begin
                if (ack[b]) begin
                    ack_cnt[b]++;
                end
            end
            if (cmd != sdram_front_pkg::cmd_nop) begin
                if (exp_q.size() == 0) begin             // new sequence picked two edges back
                    rb = next_bank(hist2, last_ba);
                    if (rb < 0) begin
                        $display("command issued while no request was pending");
                        seq_errs++;
                    end else begin
                        if (int'(cmd_ba) != rb) begin
                            $display("FAILED cmd_ba: got %h, expected %h", cmd_ba, rb);
                            seq_errs++;
                        end
                        exp_q    = expect_cmds(m_open, m_rows, rb, cur_addr[rb], cur_wr[rb]);
                        last_ba  = rb;
                        cur_bank = rb;
                    end
                end
                if (exp_q.size() > 0) begin
                    e = exp_q.pop_front();
                    if (cmd != e.cmd) begin
                        $display("FAILED cmd: got %h, expected %h", cmd, e.cmd);
                        cmd_errs++;
                    end
                    if (cmd_ba != e.ba) begin
                        $display("FAILED cmd_ba: got %h, expected %h", cmd_ba, e.ba);
                        cmd_errs++;
                    end
                    if (e.cmd != sdram_front_pkg::cmd_pre && cmd_addr != e.addr) begin
                        $display("FAILED cmd_addr: got %h, expected %h", cmd_addr, e.addr);
                        cmd_errs++;
                    end
                    if (exp_q.size() == 0 && !ack[cur_bank]) begin   // last command carries ack
                        $display("missing ack for bank %0d on its last command", cur_bank);
                        ack_errs++;
                    end
                    if ((ack & ~((exp_q.size() == 0 ? 4'b0001 : 4'b0000) << cur_bank)) != 0) begin
                        $display("unexpected ack in the middle of a sequence");
                        ack_errs++;
                    end
                    if (exp_q.size() == 0) begin
                        done[cur_bank] = 1'b1;           // request ends here in the model
                    end
                end
            end else begin
                if (exp_q.size() != 0) begin
                    $display("sequence for bank %0d broke off early", cur_bank);
                    seq_errs++;
                    exp_q.delete();
                end
                if (ack != 0) begin
                    $display("unexpected ack while the bus is idle");
                    ack_errs++;
                end
            end
            hist0 = (rd | wr) & ~done;                   // served bank still shows a stale level
        end
    end

    // watchdog
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, requests still open", cycles);
        $display("Something failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(35));                             // fixed seed
        clk = 1'b0;
        rst = 1'b1;
        rd = '0;
        wr = '0;
        addr = '0;
        cur_addr = '0;
        cur_wr = '0;
        m_open = '0;
        m_rows = '0;
        hist0 = '0;
        hist1 = '0;
        hist2 = '0;
        last_ba = sdram_front_pkg::nbank - 1;            // search starts at bank 0
        cur_bank = 0;
        cmd_errs = 0;
        ack_errs = 0;
        seq_errs = 0;
        for (int b = 0; b < sdram_front_pkg::nbank; b++) begin
            ack_cnt[b] = 0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        if (cmd != sdram_front_pkg::cmd_nop) begin
            $display("FAILED cmd: got %h, expected %h", cmd, sdram_front_pkg::cmd_nop);
            cmd_errs++;
        end
        if (ack != 0) begin
            $display("FAILED ack: got %h, expected %h", ack, {sdram_front_pkg::nbank{1'b0}});
            ack_errs++;
        end
        if (!idle) begin
            $display("FAILED idle: got %h, expected %h", idle, 1'b1);
            seq_errs++;
        end
        fork
            client(0);
            client(1);
            client(2);
            client(3);
        join
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("commands still expected after the last request");
            seq_errs++;
        end
        if (!idle) begin
            $display("FAILED idle: got %h, expected %h", idle, 1'b1);
            seq_errs++;
        end
        for (int b = 0; b < sdram_front_pkg::nbank; b++) begin
            if (ack_cnt[b] != n_per_bank) begin
                $display("bank %0d acknowledged %0d times for %0d requests",
                         b, ack_cnt[b], n_per_bank);
                ack_errs++;
            end
        end
        $display("errors: command %0d, ack %0d, sequence %0d", cmd_errs, ack_errs, seq_errs);
        if (cmd_errs + ack_errs + seq_errs == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* design/sdram_front.sv */
`timescale 1ns/1ns

module sdram_front #(
    parameter int latch_en = 1                     // register client requests
) (
    input  logic                                                     rst,
    input  logic                                                     clk,
    input  logic [sdram_front_pkg::nbank-1:0][sdram_front_pkg::aw-1:0] addr,
    input  logic [sdram_front_pkg::nbank-1:0]                        rd,
    input  logic [sdram_front_pkg::nbank-1:0]                        wr,
    output logic [sdram_front_pkg::nbank-1:0]                        ack,
    output logic [sdram_front_pkg::cmd_w-1:0]                        cmd,
    output logic [sdram_front_pkg::ba_w-1:0]                         cmd_ba,
    output logic [sdram_front_pkg::row_w-1:0]                        cmd_addr,
    output logic                                                     idle
);

    logic busy;                                    // sequence in flight

    bank_req_if req_bus ();                        // latch to sequencer
    row_upd_if  upd_bus ();                        // sequencer to tracker and back

    // ----------------------------------------------------------------------
    // input side
    // ----------------------------------------------------------------------
    bank_req_latch #(
        .latch_en (latch_en)
    ) u_latch (
        .rst  (rst),
        .clk  (clk),
        .addr (addr),
        .rd   (rd),
        .wr   (wr),
        .req  (req_bus.latch),
        .rows (upd_bus.rows)                       // row compare source
    );

    open_row_tracker u_trk (
        .rst (rst),
        .clk (clk),
        .upd (upd_bus.trk)
    );

    // ----------------------------------------------------------------------
    // output side
    // ----------------------------------------------------------------------
    bank_cmd_seq u_seq (
        .rst      (rst),
        .clk      (clk),
        .req      (req_bus.seq),
        .upd      (upd_bus.seq),
        .open     (upd_bus.open),
        .cmd      (cmd),
        .cmd_ba   (cmd_ba),
        .cmd_addr (cmd_addr),
        .ack      (ack),
        .busy     (busy)
    );

    assign idle = req_bus.noreq & ~busy;           // nothing waiting, nothing running

endmodule

/* design/bank_cmd_seq.sv */
`timescale 1ns/1ns

module bank_cmd_seq (
    input  logic                                 rst,
    input  logic                                 clk,
    bank_req_if.seq                              req,
    row_upd_if.seq                               upd,
    input  logic [sdram_front_pkg::nbank-1:0]    open,      // per-bank open flag
    output logic [sdram_front_pkg::cmd_w-1:0]    cmd,
    output logic [sdram_front_pkg::ba_w-1:0]     cmd_ba,
    output logic [sdram_front_pkg::row_w-1:0]    cmd_addr,
    output logic [sdram_front_pkg::nbank-1:0]    ack,       // one-cycle pulse on last cmd
    output logic                                 busy
);

    logic [1:0]                          state;
    logic [sdram_front_pkg::ba_w-1:0]    ba;       // bank being served
    logic [sdram_front_pkg::ba_w-1:0]    ptr;      // round-robin start point
    logic                                is_wr;    // access type captured at pick
    logic                                acked;    // previous cycle carried ack
    logic [sdram_front_pkg::nbank-1:0]   mask;     // stale request filter
    logic [sdram_front_pkg::nbank-1:0]   pend;     // live, unmasked requests
    logic [sdram_front_pkg::ba_w-1:0]    sel;      // winner of the search
    logic                                found;
    logic [sdram_front_pkg::aw-1:0]      addr_sel; // address of the served bank

    // the just-acked bank still shows its old level for one cycle
    assign mask = {{(sdram_front_pkg::nbank-1){1'b0}}, acked} << ba;
    assign pend = (req.rd_l | req.wr_l) & ~mask;

    // ----------------------------------------------------------------------
    // round-robin search, lowest offset from ptr wins
    // ----------------------------------------------------------------------
    always_comb begin : rr_search
        logic [sdram_front_pkg::ba_w-1:0] idx;
        found = 1'b0;
        sel   = ptr;
        idx   = ptr;
        for (int i = sdram_front_pkg::nbank - 1; i >= 0; i--) begin
            idx = ptr + sdram_front_pkg::ba_w'(i);
            if (pend[idx]) begin
                found = 1'b1;
                sel   = idx;                       // overwritten by closer banks
            end
        end
    end

    // ----------------------------------------------------------------------
    // FSM, one command per cycle once a bank is picked
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= sdram_front_pkg::st_pick;
            ba    <= '0;
            ptr   <= '0;
            is_wr <= 1'b0;
            acked <= 1'b0;
        end else begin
            acked <= state == sdram_front_pkg::st_acc;
            case (state)
                sdram_front_pkg::st_pick: begin
                    if (found) begin
                        ba    <= sel;
                        is_wr <= req.wr_l[sel];
                        if (!open[sel]) begin
                            state <= sdram_front_pkg::st_act;  // closed bank
                        end else if (req.match[sel]) begin
                            state <= sdram_front_pkg::st_acc;  // row hit
                        end else begin
                            state <= sdram_front_pkg::st_pre;  // row miss
                        end
                    end
                end
                sdram_front_pkg::st_pre: state <= sdram_front_pkg::st_act;
                sdram_front_pkg::st_act: state <= sdram_front_pkg::st_acc;
                default: begin
                    state <= sdram_front_pkg::st_pick;
                    ptr   <= ba + 1'b1;            // next search starts past this bank
                end
            endcase
        end
    end

    assign addr_sel = req.addr_l[ba];              // client holds it until ack

    // ----------------------------------------------------------------------
    // command bus, decoded from state
    // ----------------------------------------------------------------------
    always_comb begin
        cmd      = sdram_front_pkg::cmd_nop;
        cmd_addr = '0;
        ack      = '0;
        case (state)
            sdram_front_pkg::st_pre: cmd = sdram_front_pkg::cmd_pre;
            sdram_front_pkg::st_act: begin
                cmd      = sdram_front_pkg::cmd_act;
                cmd_addr = addr_sel[sdram_front_pkg::aw-1 -: sdram_front_pkg::row_w];
            end
            sdram_front_pkg::st_acc: begin
                cmd      = is_wr ? sdram_front_pkg::cmd_wr : sdram_front_pkg::cmd_rd;
                cmd_addr = sdram_front_pkg::row_w'(addr_sel[sdram_front_pkg::col_w-1:0]);
                ack[ba]  = 1'b1;                   // done with this request
            end
            default: cmd = sdram_front_pkg::cmd_nop;
        endcase
    end

    assign cmd_ba = ba;
    assign busy   = state != sdram_front_pkg::st_pick;

    // tracker updates ride along with the matching commands
    assign upd.act  = state == sdram_front_pkg::st_act;
    assign upd.pre  = state == sdram_front_pkg::st_pre;
    assign upd.bank = ba;
    assign upd.row  = addr_sel[sdram_front_pkg::aw-1 -: sdram_front_pkg::row_w];

    // at most one ack, and only for a bank whose request is still up
    a_ack_valid : assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(ack) && ((ack & ~(req.rd_l | req.wr_l)) == '0)
    );

endmodule

/* design/open_row_tracker.sv */
`timescale 1ns/1ns

module open_row_tracker (
    input  logic    rst,
    input  logic    clk,
    row_upd_if.trk  upd
);

    // ----------------------------------------------------------------------
    // open flags, all banks closed after reset
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            upd.open <= '0;
        end else begin
            if (upd.act) begin
                upd.open[upd.bank] <= 1'b1;        // row now open
            end
            if (upd.pre) begin
                upd.open[upd.bank] <= 1'b0;        // bank closed again
            end
        end
    end

    // ----------------------------------------------------------------------
    // row store, only meaningful while the open flag is set
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (upd.act) begin
            upd.rows[upd.bank] <= upd.row;         // remember which row went up
        end
    end

    // act and pre come from different FSM states
    a_act_pre_excl : assert property (
        @(posedge clk) disable iff (rst) !(upd.act && upd.pre)
    );

    // an open bank is always precharged before the next activate
    a_act_closed : assert property (
        @(posedge clk) disable iff (rst) upd.act |-> !upd.open[upd.bank]
    );

endmodule

/* design/bank_req_latch.sv */
`timescale 1ns/1ns

module bank_req_latch #(
    parameter int latch_en = 1                 // 1 registers, 0 passes through
) (
    input  logic                                                     rst,
    input  logic                                                     clk,
    input  logic [sdram_front_pkg::nbank-1:0][sdram_front_pkg::aw-1:0] addr,
    input  logic [sdram_front_pkg::nbank-1:0]                        rd,
    input  logic [sdram_front_pkg::nbank-1:0]                        wr,
    bank_req_if.latch                                                req,
    input  logic [sdram_front_pkg::nbank-1:0][sdram_front_pkg::row_w-1:0] rows
);

    logic [sdram_front_pkg::nbank-1:0] hit_now;    // row compare on live inputs
    logic                              noreq_now;  // nothing requested right now

    // ----------------------------------------------------------------------
    // row compare, top row_w bits of each address against the tracker
    // ----------------------------------------------------------------------
    always_comb begin
        for (int b = 0; b < sdram_front_pkg::nbank; b++) begin
            hit_now[b] = addr[b][sdram_front_pkg::aw-1 -: sdram_front_pkg::row_w] == rows[b];
        end
    end

    assign noreq_now = ~|{rd, wr};                 // idle when no level is up

    generate
        if (latch_en == 1) begin : g_reg
            // control side, cleared on reset
            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    req.rd_l  <= '0;
                    req.wr_l  <= '0;
                    req.match <= '0;
                    req.noreq <= 1'b1;             // nothing pending out of reset
                end else begin
                    req.rd_l  <= rd;
                    req.wr_l  <= wr;
                    req.match <= hit_now;          // compared against rows of this cycle
                    req.noreq <= noreq_now;
                end
            end

            always_ff @(posedge clk) begin
                req.addr_l <= addr;                // address word, one clock late
            end
        end else begin : g_comb
            always_comb begin
                req.addr_l = addr;
                req.rd_l   = rd;
                req.wr_l   = wr;
                req.match  = hit_now;
                req.noreq  = noreq_now;
            end
        end
    endgenerate

    // a client never asks to read and write the same bank at once
    a_rd_wr_excl : assert property (
        @(posedge clk) disable iff (rst) (rd & wr) == '0
    );

endmodule

/* design/row_upd_if.sv */
`timescale 1ns/1ns

// open/close updates to the row tracker and its state back out
interface row_upd_if;

    logic                               act;   // one-cycle activate strobe
    logic                               pre;   // one-cycle precharge strobe
    logic [sdram_front_pkg::ba_w-1:0]   bank;  // target of act or pre
    logic [sdram_front_pkg::row_w-1:0]  row;   // row being opened

    // tracker state, valid the cycle after a strobe
    logic [sdram_front_pkg::nbank-1:0][sdram_front_pkg::row_w-1:0] rows;
    logic [sdram_front_pkg::nbank-1:0]                             open;

    modport seq (
        output act, pre, bank, row
    );

    modport trk (
        input  act, pre, bank, row,
        output rows, open
    );

endinterface

/* design/bank_req_if.sv */
`timescale 1ns/1ns

// conditioned client requests, latch side to sequencer side
interface bank_req_if;

    // one address word per bank, held by the client until ack
    logic [sdram_front_pkg::nbank-1:0][sdram_front_pkg::aw-1:0] addr_l;

    logic [sdram_front_pkg::nbank-1:0] rd_l;   // read level per bank
    logic [sdram_front_pkg::nbank-1:0] wr_l;   // write level per bank
    logic [sdram_front_pkg::nbank-1:0] match;  // row field equals tracked row
    logic                              noreq;  // no strobe anywhere

    modport latch (
        output addr_l,
        output rd_l,
        output wr_l,
        output match,
        output noreq
    );

    modport seq (
        input  addr_l,
        input  rd_l,
        input  wr_l,
        input  match,
        input  noreq
    );

endinterface

/* design/sdram_front_pkg.sv */
package sdram_front_pkg;

    // ----------------------------------------------------------------------
    // client address split
    // ----------------------------------------------------------------------
    localparam int aw    = 22;            // client word address width
    localparam int row_w = 13;            // row field, addr[21:9]
    localparam int col_w = 9;             // column field, addr[8:0]

    // ----------------------------------------------------------------------
    // bank geometry
    // ----------------------------------------------------------------------
    localparam int nbank = 4;             // one client port per bank
    localparam int ba_w  = $clog2(nbank); // bank select width

    // ----------------------------------------------------------------------
    // sdram command codes
    // ----------------------------------------------------------------------
    localparam int cmd_w = 3;

    localparam logic [cmd_w-1:0] cmd_nop = 3'd0;  // idle bus
    localparam logic [cmd_w-1:0] cmd_act = 3'd1;  // open a row
    localparam logic [cmd_w-1:0] cmd_pre = 3'd2;  // close the bank's row
    localparam logic [cmd_w-1:0] cmd_rd  = 3'd3;  // column read
    localparam logic [cmd_w-1:0] cmd_wr  = 3'd4;  // column write

    // sequencer FSM states, named after the command each one issues
    localparam logic [1:0] st_pick = 2'd0;  // choose the next bank, bus is nop
    localparam logic [1:0] st_pre  = 2'd1;  // precharge the open row
    localparam logic [1:0] st_act  = 2'd2;  // activate the requested row
    localparam logic [1:0] st_acc  = 2'd3;  // read or write, plus ack

endpackage
